/* serial_framing_macros.svh */
`ifndef SERIAL_FRAMING_MACROS_SVH
`define SERIAL_FRAMING_MACROS_SVH

// ----------------------------------------
// buffer depths

`define RING_BITS 6        // send and message rings hold 64 bytes
`define LEN_FIFO_BITS 2    // four queued frame lengths
`define LINK_DEPTH 8       // link FIFO entries, also the initial credit count

// ----------------------------------------
// frame format

`define FRAME_SYNC 8'h7e   // closes every frame, may also pad between frames
`define SEQ_MARKER 4'h1    // upper nibble of the sequence byte
`define FRAME_OVERHEAD 5   // length, sequence, two CRC bytes and sync
`define MAX_PAYLOAD 58     // keeps the length byte at 63 or below

`endif

/* frame_pkg.sv */
`default_nettype none

package frame_pkg;

	typedef enum logic [2:0] {
		ENC_IDLE,      // waiting for a length entry
		ENC_LEN,
		ENC_SEQ,
		ENC_DATA,
		ENC_CRC_HI,
		ENC_CRC_LO,
		ENC_SYNC
	} enc_state_e;

	typedef enum logic [2:0] {
		DEC_LEN,       // stray sync bytes between frames are skipped here
		DEC_SEQ,
		DEC_DATA,
		DEC_CRC_HI,
		DEC_CRC_LO,
		DEC_SYNC,
		DEC_FAULT      // sticky until clr
	} dec_state_e;

	typedef enum logic [2:0] {
		ERR_NONE,
		ERR_BAD_LEN,
		ERR_BAD_CRC,
		ERR_BAD_SEQ,
		ERR_BAD_MARKER,
		ERR_NO_SYNC
	} frame_err_e;

endpackage

`default_nettype wire

/* link_pkg.sv */
`default_nettype none

`include "serial_framing_macros.svh"

package link_pkg;

	typedef logic [`RING_BITS-1:0] ring_ptr_t;                  // send and message rings

	// must reach LINK_DEPTH itself, not only LINK_DEPTH-1
	typedef logic [$clog2(`LINK_DEPTH + 1)-1:0] credit_t;

	typedef logic [5:0] len_t;                                 // payload length of one frame

endpackage

`default_nettype wire

/* crc16_ccitt.sv */
`default_nettype none

module crc16_ccitt (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        start,
	input  wire logic        load,
	input  wire logic [7:0]  data,
	output logic             busy,
	output logic [15:0]      crc
);

	logic [7:0] shift_in;      // byte being absorbed, lsb first
	logic [3:0] bit_cnt;       // bits still to absorb
	logic       feedback;

	assign busy = (bit_cnt != 4'd0);
	assign feedback = shift_in[0] ^ crc[0];

	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt <= 4'd0;
		end else if (load) begin
			bit_cnt <= 4'd8;
		end else if (busy) begin
			bit_cnt <= bit_cnt - 1'b1;
		end
	end

	// reflected polynomial 0x8408, one bit per cycle
	always_ff @(posedge clk) begin
		if (start) begin
			crc <= 16'hffff;                             // a load in the same cycle shifts from here
		end else if (busy) begin
			crc <= {feedback, crc[15:12], crc[11] ^ feedback, crc[10:5],
				crc[4] ^ feedback, crc[3:1]};
		end
		if (load) begin
			shift_in <= data;
		end else if (busy) begin
			shift_in <= {1'b0, shift_in[7:1]};
		end
	end

endmodule

`default_nettype wire

/* frame_encoder.sv */
`default_nettype none

`include "serial_framing_macros.svh"

module frame_encoder import frame_pkg::*, link_pkg::*; (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        clr,
	input  wire logic        len_wr_en,
	input  wire len_t        len_data,
	output logic             len_full,
	input  wire logic        pay_wr_en,
	input  wire logic [7:0]  pay_data,
	output logic             pay_full,
	output logic             tx_valid,
	output logic [7:0]       tx_byte,
	input  wire logic        tx_credit
);

	localparam int RING_SIZE = 1 << `RING_BITS;
	localparam int LEN_DEPTH = 1 << `LEN_FIFO_BITS;

	logic [7:0]              pay_ring [RING_SIZE];
	ring_ptr_t               pay_wptr;
	ring_ptr_t               pay_rptr;
	len_t                    len_mem [LEN_DEPTH];
	logic [`LEN_FIFO_BITS:0] len_wptr;                          // extra bit tells full from empty
	logic [`LEN_FIFO_BITS:0] len_rptr;
	logic                    len_empty;

	enc_state_e  state;
	len_t        len_cnt;           // payload bytes still to send
	logic [3:0]  seq;
	credit_t     credits;
	logic        emit;
	logic [7:0]  next_byte;
	logic        crc_start;
	logic        crc_load;
	logic        crc_busy;
	logic [15:0] crc;

	assign pay_full = (ring_ptr_t'(pay_wptr + 1'b1) == pay_rptr);
	assign len_empty = (len_wptr == len_rptr);
	assign len_full = (len_wptr[`LEN_FIFO_BITS] != len_rptr[`LEN_FIFO_BITS]) &&
		(len_wptr[`LEN_FIFO_BITS-1:0] == len_rptr[`LEN_FIFO_BITS-1:0]);

	// one byte per emit, never back to back and never into a running CRC
	assign emit = (state != ENC_IDLE) && (credits != '0) && !crc_busy && !tx_valid;

	always_comb begin
		case (state)
			ENC_LEN:    next_byte = 8'({2'b00, len_cnt} + `FRAME_OVERHEAD);
			ENC_SEQ:    next_byte = {`SEQ_MARKER, seq};
			ENC_DATA:   next_byte = pay_ring[pay_rptr];
			ENC_CRC_HI: next_byte = crc[15:8];
			ENC_CRC_LO: next_byte = crc[7:0];
			default:    next_byte = `FRAME_SYNC;
		endcase
	end

	assign crc_start = emit && (state == ENC_LEN);
	assign crc_load = emit && (state == ENC_LEN || state == ENC_SEQ || state == ENC_DATA);

	crc16_ccitt u_crc (
		.clk   (clk),
		.reset (reset),
		.start (crc_start),
		.load  (crc_load),
		.data  (next_byte),
		.busy  (crc_busy),
		.crc   (crc)
	);

	// ----------------------------------------
	// payload ring, length FIFO and output byte

	always_ff @(posedge clk) begin
		if (pay_wr_en && !pay_full) begin
			pay_ring[pay_wptr] <= pay_data;
		end
		if (len_wr_en && !len_full) begin
			len_mem[len_wptr[`LEN_FIFO_BITS-1:0]] <= len_data;
		end
		if (emit) begin
			tx_byte <= next_byte;
		end
	end

	// ----------------------------------------
	// frame builder

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ENC_IDLE;
			tx_valid <= 1'b0;
			credits <= credit_t'(`LINK_DEPTH);
			seq <= 4'd0;
			len_cnt <= '0;
			pay_wptr <= '0;
			pay_rptr <= '0;
			len_wptr <= '0;
			len_rptr <= '0;
		end else begin
			tx_valid <= emit;
			case ({emit, tx_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: ;                                         // spent and returned cancel out
			endcase
			if (pay_wr_en && !pay_full) begin
				pay_wptr <= pay_wptr + 1'b1;
			end
			if (len_wr_en && !len_full) begin
				len_wptr <= len_wptr + 1'b1;
			end

			if (state == ENC_IDLE) begin
				if (!len_empty) begin
					len_cnt <= len_mem[len_rptr[`LEN_FIFO_BITS-1:0]];
					len_rptr <= len_rptr + 1'b1;
					state <= ENC_LEN;
				end
			end else if (emit) begin
				case (state)
					ENC_LEN: state <= ENC_SEQ;
					ENC_SEQ: begin
						seq <= seq + 1'b1;
						state <= (len_cnt == '0) ? ENC_CRC_HI : ENC_DATA;
					end
					ENC_DATA: begin
						pay_rptr <= pay_rptr + 1'b1;
						len_cnt <= len_cnt - 1'b1;
						if (len_cnt == len_t'(1)) begin
							state <= ENC_CRC_HI;
						end
					end
					ENC_CRC_HI: state <= ENC_CRC_LO;
					ENC_CRC_LO: state <= ENC_SYNC;
					default:    state <= ENC_IDLE;                // sync byte closes the frame
				endcase
			end

			if (clr) begin
				seq <= 4'd0;                                       // resynchronize with the decoder
			end
		end
	end

endmodule

`default_nettype wire

/* link_fifo.sv */
`default_nettype none

`include "serial_framing_macros.svh"

module link_fifo (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        rx_valid,
	input  wire logic [7:0]  rx_byte,
	output logic             byte_valid,
	output logic [7:0]       byte_data,
	input  wire logic        byte_pop,
	output logic             rx_credit
);

	localparam int ADDR_BITS = $clog2(`LINK_DEPTH);

	logic [7:0]         mem [`LINK_DEPTH];
	logic [ADDR_BITS:0] wptr;              // msb is the wrap bit
	logic [ADDR_BITS:0] rptr;
	logic               full;
	logic               pop;

	assign byte_valid = (wptr != rptr);
	assign byte_data = mem[rptr[ADDR_BITS-1:0]];
	assign full = (wptr[ADDR_BITS] != rptr[ADDR_BITS]) &&
		(wptr[ADDR_BITS-1:0] == rptr[ADDR_BITS-1:0]);
	assign pop = byte_pop && byte_valid;

	always_ff @(posedge clk) begin
		if (rx_valid && !full) begin
			mem[wptr[ADDR_BITS-1:0]] <= rx_byte;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wptr <= '0;
			rptr <= '0;
			rx_credit <= 1'b0;
		end else begin
			if (rx_valid && !full) begin
				wptr <= wptr + 1'b1;
			end
			if (pop) begin
				rptr <= rptr + 1'b1;
			end
			rx_credit <= pop;                  // freed slot goes back to the sender
		end
	end

endmodule

`default_nettype wire

/* frame_decoder.sv */
`default_nettype none

`include "serial_framing_macros.svh"

module frame_decoder import frame_pkg::*, link_pkg::*; (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        clr,
	input  wire logic        byte_valid,
	input  wire logic [7:0]  byte_data,
	output logic             byte_pop,
	output logic             msg_ready,
	output logic [7:0]       msg_data,
	input  wire logic        msg_rd_en,
	output logic             error,
	output frame_err_e       err_code
);

	localparam int RING_SIZE = 1 << `RING_BITS;

	logic [7:0]  msg_ring [RING_SIZE];
	ring_ptr_t   wptr;             // end of committed bytes
	ring_ptr_t   tmp_wptr;         // provisional write position
	ring_ptr_t   rptr;
	ring_ptr_t   base_wptr;
	logic        commit;
	logic        room;

	dec_state_e  state;
	frame_err_e  cause;
	len_t        len_cnt;
	logic [3:0]  exp_seq;
	logic [7:0]  crc_hi;
	logic        is_sync;
	logic        crc_start;
	logic        crc_load;
	logic        crc_busy;
	logic [15:0] crc;

	assign msg_ready = (rptr != wptr);
	assign msg_data = msg_ring[rptr];
	assign room = (ring_ptr_t'(tmp_wptr + 1'b1) != rptr);
	assign is_sync = (byte_data == `FRAME_SYNC);

	// committed pointer including a commit still in flight
	assign base_wptr = commit ? tmp_wptr : wptr;

	assign byte_pop = byte_valid && !clr && !crc_busy && (state != DEC_DATA || room);

	assign crc_start = byte_pop && (state == DEC_LEN) && !is_sync;
	assign crc_load = crc_start || (byte_pop && (state == DEC_SEQ || state == DEC_DATA));

	crc16_ccitt u_crc (
		.clk   (clk),
		.reset (reset),
		.start (crc_start),
		.load  (crc_load),
		.data  (byte_data),
		.busy  (crc_busy),
		.crc   (crc)
	);

	// ----------------------------------------
	// per-byte checks

	always_comb begin
		cause = ERR_NONE;
		case (state)
			DEC_LEN: begin
				if (!is_sync && (byte_data < 8'(`FRAME_OVERHEAD) ||
					byte_data > 8'(`FRAME_OVERHEAD + `MAX_PAYLOAD))) begin
					cause = ERR_BAD_LEN;
				end
			end
			DEC_SEQ: begin
				if (byte_data[7:4] != `SEQ_MARKER) begin
					cause = ERR_BAD_MARKER;                // marker wins over the count
				end else if (byte_data[3:0] != exp_seq) begin
					cause = ERR_BAD_SEQ;
				end
			end
			DEC_CRC_LO: begin
				if ({crc_hi, byte_data} != crc) begin
					cause = ERR_BAD_CRC;
				end
			end
			DEC_SYNC: begin
				if (!is_sync) begin
					cause = ERR_NO_SYNC;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (byte_pop && state == DEC_DATA) begin
			msg_ring[tmp_wptr] <= byte_data;
		end
		if (byte_pop && state == DEC_CRC_HI) begin
			crc_hi <= byte_data;
		end
	end

	// ----------------------------------------
	// frame checker

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= DEC_LEN;
			error <= 1'b0;
			err_code <= ERR_NONE;
			exp_seq <= 4'd0;
			len_cnt <= '0;
			wptr <= '0;
			tmp_wptr <= '0;
			rptr <= '0;
			commit <= 1'b0;
		end else begin
			commit <= 1'b0;
			if (commit) begin
				wptr <= tmp_wptr;                              // frame becomes visible to the reader
			end
			if (msg_rd_en && msg_ready) begin
				rptr <= rptr + 1'b1;
			end

			if (clr) begin
				state <= DEC_LEN;
				error <= 1'b0;
				err_code <= ERR_NONE;
				exp_seq <= 4'd0;
				tmp_wptr <= base_wptr;                         // drop uncommitted bytes
			end else if (byte_pop) begin
				if (cause != ERR_NONE) begin
					state <= DEC_FAULT;
					error <= 1'b1;
					err_code <= cause;
				end else begin
					case (state)
						DEC_LEN: begin
							if (!is_sync) begin
								len_cnt <= len_t'(byte_data - 8'(`FRAME_OVERHEAD));
								state <= DEC_SEQ;
							end
						end
						DEC_SEQ: state <= (len_cnt == '0) ? DEC_CRC_HI : DEC_DATA;
						DEC_DATA: begin
							tmp_wptr <= tmp_wptr + 1'b1;
							len_cnt <= len_cnt - 1'b1;
							if (len_cnt == len_t'(1)) begin
								state <= DEC_CRC_HI;
							end
						end
						DEC_CRC_HI: state <= DEC_CRC_LO;
						DEC_CRC_LO: state <= DEC_SYNC;
						DEC_SYNC: begin
							commit <= 1'b1;
							exp_seq <= exp_seq + 1'b1;
							state <= DEC_LEN;
						end
						default: ;                                 // in FAULT bytes are popped and dropped
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

/* serial_framing_top.sv */
`default_nettype none

module serial_framing_top import frame_pkg::*, link_pkg::*; (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        clr,

	input  wire logic        len_wr_en,
	input  wire len_t        len_data,
	output logic             len_full,
	input  wire logic        pay_wr_en,
	input  wire logic [7:0]  pay_data,
	output logic             pay_full,

	output logic             tx_valid,
	output logic [7:0]       tx_byte,
	input  wire logic        tx_credit,

	input  wire logic        rx_valid,
	input  wire logic [7:0]  rx_byte,
	output logic             rx_credit,

	output logic             msg_ready,
	output logic [7:0]       msg_data,
	input  wire logic        msg_rd_en,
	output logic             error,
	output frame_err_e       err_code
);

	logic       byte_valid;       // link FIFO to decoder
	logic [7:0] byte_data;
	logic       byte_pop;

	// ----------------------------------------
	// transmit path

	frame_encoder u_encoder (
		.clk       (clk),
		.reset     (reset),
		.clr       (clr),
		.len_wr_en (len_wr_en),
		.len_data  (len_data),
		.len_full  (len_full),
		.pay_wr_en (pay_wr_en),
		.pay_data  (pay_data),
		.pay_full  (pay_full),
		.tx_valid  (tx_valid),
		.tx_byte   (tx_byte),
		.tx_credit (tx_credit)
	);

	// ----------------------------------------
	// receive path

	link_fifo u_link_fifo (
		.clk        (clk),
		.reset      (reset),
		.rx_valid   (rx_valid),
		.rx_byte    (rx_byte),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.byte_pop   (byte_pop),
		.rx_credit  (rx_credit)
	);

	frame_decoder u_decoder (
		.clk        (clk),
		.reset      (reset),
		.clr        (clr),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.byte_pop   (byte_pop),
		.msg_ready  (msg_ready),
		.msg_data   (msg_data),
		.msg_rd_en  (msg_rd_en),
		.error      (error),
		.err_code   (err_code)
	);

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;            // period of 10
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);        // two edges see reset high
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

/* tb_serial_framing.sv */
`default_nettype none

`include "serial_framing_macros.svh"

module tb_serial_framing import frame_pkg::*, link_pkg::*; ();

	localparam int NUM_FRAMES = 3 + 40 + 4 + 5 + 2;           // frames over all tests
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * 64 * 10 * 2;

	logic       clk;
	logic       reset;
	logic       clr = 1'b0;
	logic       len_wr_en = 1'b0;
	len_t       len_data = '0;
	logic       len_full;
	logic       pay_wr_en = 1'b0;
	logic [7:0] pay_data = '0;
	logic       pay_full;
	logic       tx_valid;
	logic [7:0] tx_byte;
	logic       tx_credit = 1'b0;
	logic       rx_valid = 1'b0;
	logic [7:0] rx_byte = '0;
	logic       rx_credit;
	logic       msg_ready;
	logic [7:0] msg_data;
	logic       msg_rd_en = 1'b0;
	logic       error;
	frame_err_e err_code;

	logic [7:0] pay_buf [64];         // payload of the frame being built
	logic [7:0] exp_q [$];            // bytes that must commit, oldest first
	logic [7:0] raw_q [$];            // bytes injected straight into the link
	logic [7:0] tx_log [$];           // every byte the encoder sent

	bit         loop_en = 1'b1;
	bit         stall_mode = 1'b0;
	int         corrupt_at = -1;      // index into the transmitted byte stream
	int         stall_left = 0;
	int         tx_total = 0;
	int         tx_expect = 0;
	int         enc_sent = 0;
	int         enc_returned = 0;
	int         rx_pushed = 0;
	int         credits_seen = 0;
	int         cycles = 0;
	int         err_count = 0;
	int         pass_count = 0;
	int         fail_count = 0;
	logic [3:0] frame_seq = 4'd0;
	logic       tx_v_s = 1'b0;        // encoder output sampled mid-cycle
	logic [7:0] tx_b_s = '0;
	logic       rc_s = 1'b0;

	tb_clock_gen u_clock (
		.clk   (clk),
		.reset (reset)
	);

	serial_framing_top DUT (
		.clk       (clk),
		.reset     (reset),
		.clr       (clr),
		.len_wr_en (len_wr_en),
		.len_data  (len_data),
		.len_full  (len_full),
		.pay_wr_en (pay_wr_en),
		.pay_data  (pay_data),
		.pay_full  (pay_full),
		.tx_valid  (tx_valid),
		.tx_byte   (tx_byte),
		.tx_credit (tx_credit),
		.rx_valid  (rx_valid),
		.rx_byte   (rx_byte),
		.rx_credit (rx_credit),
		.msg_ready (msg_ready),
		.msg_data  (msg_data),
		.msg_rd_en (msg_rd_en),
		.error     (error),
		.err_code  (err_code)
	);

	// ----------------------------------------
	// link monitor and loopback

	always @(negedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles because the link never went idle", cycles);
			$display("TEST FAIL");
			$finish;
		end else begin
			tx_v_s = 1'b0;
			rc_s = 1'b0;
			if (!reset) begin
				if (tx_valid) begin
					tx_log.push_back(tx_byte);
					tx_v_s = 1'b1;
					tx_b_s = (tx_total == corrupt_at) ? tx_byte ^ 8'h01 : tx_byte;
					tx_total++;
					enc_sent++;
				end
				if (tx_credit) begin
					enc_returned++;
				end
				if (rx_credit) begin
					rc_s = 1'b1;
					credits_seen++;
				end
				if (enc_sent - enc_returned > `LINK_DEPTH) begin
					$display("encoder has more bytes in flight than the link FIFO holds");
					err_count++;
				end
			end
		end
	end

	always @(posedge clk) begin
		if (loop_en) begin
			rx_valid <= tx_v_s;
			rx_byte <= tx_b_s;
			tx_credit <= rc_s;
			if (tx_v_s) begin
				rx_pushed++;
			end
		end else if (raw_q.size() != 0 && rx_pushed - credits_seen < `LINK_DEPTH) begin
			rx_valid <= 1'b1;
			rx_byte <= raw_q.pop_front();
			tx_credit <= 1'b0;
			rx_pushed++;
		end else begin
			rx_valid <= 1'b0;
			tx_credit <= 1'b0;
		end
	end

	// reader with optional random stalls, long enough to fill the message ring
	always @(posedge clk) begin
		if (stall_left > 0) begin
			msg_rd_en <= 1'b0;
			stall_left--;
		end else if (stall_mode && $urandom_range(0, 31) == 0) begin
			msg_rd_en <= 1'b0;
			stall_left = $urandom_range(200, 600);
		end else begin
			msg_rd_en <= 1'b1;
		end
	end

	always @(negedge clk) begin : check_messages
		logic [7:0] want;
		if (!reset && msg_rd_en && msg_ready) begin
			if (exp_q.size() == 0) begin
				$display("message byte %h was read although no byte was expected", msg_data);
				err_count++;
			end else begin
				want = exp_q.pop_front();
				if (msg_data !== want) begin
					$display("CHECK FAILED msg_data got %h expected %h", msg_data, want);
					err_count++;
				end
			end
		end
	end

	// ----------------------------------------
	// reference model

	function automatic logic [15:0] crc_byte(input logic [15:0] c_in, input logic [7:0] b);
		logic [15:0] c;
		int k;
		c = c_in ^ {8'h00, b};
		for (k = 0; k < 8; k++) begin
			c = c[0] ? ((c >> 1) ^ 16'h8408) : (c >> 1);
		end
		return c;
	endfunction

	function automatic logic [15:0] frame_crc(input logic [7:0] len_b, input logic [7:0] seq_b,
		input int n);
		logic [15:0] c;
		int i;
		c = crc_byte(16'hffff, len_b);
		c = crc_byte(c, seq_b);
		for (i = 0; i < n; i++) begin
			c = crc_byte(c, pay_buf[i]);
		end
		return c;
	endfunction

	// ----------------------------------------
	// helpers

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] want);
		if (got !== want) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, want);
			err_count++;
		end
	endtask

	task automatic fill_payload(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			pay_buf[i] = 8'($urandom);
		end
	endtask

	task automatic queue_frame(input int n, input bit deliver);
		int i;
		for (i = 0; i < n; i++) begin
			@(negedge clk);
			while (pay_full) @(negedge clk);
			@(posedge clk);
			pay_wr_en <= 1'b1;
			pay_data <= pay_buf[i];
			@(posedge clk);
			pay_wr_en <= 1'b0;
		end
		if (deliver) begin
			for (i = 0; i < n; i++) begin
				exp_q.push_back(pay_buf[i]);
			end
		end
		tx_expect += n + `FRAME_OVERHEAD;
		frame_seq++;
		@(negedge clk);
		while (len_full) @(negedge clk);
		@(posedge clk);
		len_wr_en <= 1'b1;
		len_data <= len_t'(n);
		@(posedge clk);
		len_wr_en <= 1'b0;
	endtask

	task automatic inject_frame(input int n, input logic [7:0] seq_b, input logic [7:0] last_b,
		input bit deliver);
		logic [15:0] crc;
		int i;
		crc = frame_crc(8'(n + `FRAME_OVERHEAD), seq_b, n);
		raw_q.push_back(8'(n + `FRAME_OVERHEAD));
		raw_q.push_back(seq_b);
		for (i = 0; i < n; i++) begin
			raw_q.push_back(pay_buf[i]);
			if (deliver) begin
				exp_q.push_back(pay_buf[i]);
			end
		end
		raw_q.push_back(crc[15:8]);
		raw_q.push_back(crc[7:0]);
		raw_q.push_back(last_b);
	endtask

	// all bytes sent, popped and credited, and every expected byte read
	task automatic wait_all_done();
		@(negedge clk);
		while (tx_total != tx_expect || raw_q.size() != 0 || rx_pushed != credits_seen ||
			enc_sent != enc_returned) begin
			@(negedge clk);
		end
		while (exp_q.size() != 0) @(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	task automatic check_tx_frame(input int base, input int n, input logic [3:0] seq);
		logic [15:0] crc;
		int i;
		crc = frame_crc(8'(n + `FRAME_OVERHEAD), {`SEQ_MARKER, seq}, n);
		if (tx_log.size() < base + n + `FRAME_OVERHEAD) begin
			$display("encoder sent fewer bytes than a frame with %0d payload bytes needs", n);
			err_count++;
		end else begin
			check_value("tx_byte length", 16'(tx_log[base]), 16'(n + `FRAME_OVERHEAD));
			check_value("tx_byte sequence", 16'(tx_log[base + 1]), 16'({`SEQ_MARKER, seq}));
			for (i = 0; i < n; i++) begin
				check_value("tx_byte payload", 16'(tx_log[base + 2 + i]), 16'(pay_buf[i]));
			end
			check_value("tx_byte crc high", 16'(tx_log[base + 2 + n]), 16'(crc[15:8]));
			check_value("tx_byte crc low", 16'(tx_log[base + 3 + n]), 16'(crc[7:0]));
			check_value("tx_byte sync", 16'(tx_log[base + 4 + n]), 16'(`FRAME_SYNC));
		end
	endtask

	task automatic expect_error(input frame_err_e code);
		if (error !== 1'b1) begin
			$display("error flag stayed low although the frame was faulty");
			err_count++;
		end
		check_value("err_code", 16'(err_code), 16'(code));
	endtask

	task automatic pulse_clr();
		@(posedge clk);
		clr <= 1'b1;
		@(posedge clk);
		clr <= 1'b0;
		frame_seq = 4'd0;             // both ends restart at zero
		@(negedge clk);
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		if (err_count == errs_before) begin
			$display("test %0d %s: ok", num, name);
			pass_count++;
		end else begin
			$display("test %0d %s: failed with %0d errors", num, name, err_count - errs_before);
			fail_count++;
		end
	endtask

	// ----------------------------------------
	// test sequence

	initial begin
		int errs;
		int i;
		int n;
		int base;
		logic [3:0] seq;

		n = $urandom(35312);
		@(negedge clk);
		while (reset) @(negedge clk);

		errs = err_count;
		check_value("msg_ready", 16'(msg_ready), 16'h0);
		check_value("error", 16'(error), 16'h0);
		check_value("tx_valid", 16'(tx_valid), 16'h0);
		check_value("rx_credit", 16'(rx_credit), 16'h0);
		check_value("len_full", 16'(len_full), 16'h0);
		check_value("pay_full", 16'(pay_full), 16'h0);
		check_value("err_code", 16'(err_code), 16'(ERR_NONE));
		report_test(1, "reset state", errs);

		errs = err_count;
		for (i = 0; i < 3; i++) begin
			n = (i == 0) ? 0 : (i == 1) ? 1 : `MAX_PAYLOAD;
			fill_payload(n);
			base = tx_total;
			seq = frame_seq;
			queue_frame(n, 1'b1);
			wait_all_done();
			check_tx_frame(base, n, seq);
		end
		check_value("error", 16'(error), 16'h0);
		report_test(2, "single frames", errs);

		errs = err_count;
		stall_mode = 1'b1;
		for (i = 0; i < 40; i++) begin
			n = $urandom_range(0, `MAX_PAYLOAD);
			fill_payload(n);
			queue_frame(n, 1'b1);
		end
		wait_all_done();
		stall_mode = 1'b0;
		check_value("error", 16'(error), 16'h0);
		report_test(3, "back-to-back random frames", errs);

		errs = err_count;
		fill_payload(8);
		corrupt_at = tx_total + 3;    // second payload byte
		queue_frame(8, 1'b0);
		wait_all_done();
		expect_error(ERR_BAD_CRC);
		check_value("msg_ready", 16'(msg_ready), 16'h0);
		pulse_clr();
		corrupt_at = -1;
		for (i = 0; i < 3; i++) begin
			n = $urandom_range(1, 20);
			fill_payload(n);
			queue_frame(n, 1'b1);
		end
		wait_all_done();
		check_value("error", 16'(error), 16'h0);
		report_test(4, "corrupted payload and recovery", errs);

		errs = err_count;
		loop_en = 1'b0;
		raw_q.push_back(8'd70);
		wait_all_done();
		expect_error(ERR_BAD_LEN);
		pulse_clr();
		fill_payload(4);
		inject_frame(4, {`SEQ_MARKER, 4'd0}, 8'h55, 1'b0);
		wait_all_done();
		expect_error(ERR_NO_SYNC);
		check_value("msg_ready", 16'(msg_ready), 16'h0);
		pulse_clr();
		fill_payload(3);
		inject_frame(3, 8'h20, `FRAME_SYNC, 1'b0);
		wait_all_done();
		expect_error(ERR_BAD_MARKER);
		pulse_clr();
		fill_payload(2);
		inject_frame(2, {`SEQ_MARKER, 4'd0}, `FRAME_SYNC, 1'b1);
		fill_payload(2);
		inject_frame(2, {`SEQ_MARKER, 4'd2}, `FRAME_SYNC, 1'b0);
		wait_all_done();
		expect_error(ERR_BAD_SEQ);
		pulse_clr();
		check_value("error", 16'(error), 16'h0);
		check_value("msg_ready", 16'(msg_ready), 16'h0);
		report_test(5, "injected faults", errs);

		errs = err_count;
		raw_q.push_back(`FRAME_SYNC);
		raw_q.push_back(`FRAME_SYNC);
		fill_payload(3);
		inject_frame(3, {`SEQ_MARKER, 4'd0}, `FRAME_SYNC, 1'b1);
		for (i = 0; i < 3; i++) begin
			raw_q.push_back(`FRAME_SYNC);
		end
		fill_payload(5);
		inject_frame(5, {`SEQ_MARKER, 4'd1}, `FRAME_SYNC, 1'b1);
		raw_q.push_back(`FRAME_SYNC);
		wait_all_done();
		check_value("error", 16'(error), 16'h0);
		check_value("err_code", 16'(err_code), 16'(ERR_NONE));
		report_test(6, "extra sync bytes", errs);

		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0 && err_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* serial_framing.f */
+incdir+.
frame_pkg.sv
link_pkg.sv
crc16_ccitt.sv
frame_encoder.sv
link_fifo.sv
frame_decoder.sv
serial_framing_top.sv
tb_clock_gen.sv
tb_serial_framing.sv

/* Bender.yml */
package:
  name: serial_framing

sources:
  - include_dirs:
      - .
    files:
      - frame_pkg.sv
      - link_pkg.sv
      - crc16_ccitt.sv
      - frame_encoder.sv
      - link_fifo.sv
      - frame_decoder.sv
      - serial_framing_top.sv
      - target: test
        files:
          - tb_clock_gen.sv
          - tb_serial_framing.sv
